/* design/tag_pkg.sv */
// tag pool constants and FSM states; TAG_COUNT must be a power of two equal to 2**TAG_WIDTH
package tag_pkg;

	////////////////////////////////////////////////////////////////////////////
	// tag pool sizing
	////////////////////////////////////////////////////////////////////////////

	// number of tickets in circulation
	localparam int TAG_COUNT = 16;
	// bits per tag, log2 of the pool size
	localparam int TAG_WIDTH = 4;

	// one tag as carried on the command and response buses
	typedef logic [TAG_WIDTH-1:0] tag_t;

	////////////////////////////////////////////////////////////////////////////
	// tag buffer FSM
	////////////////////////////////////////////////////////////////////////////

	// reset holds one cycle, init walks the pool, ready serves commands
	typedef enum logic [1:0] {
		TAG_BUFFER_RESET = 2'd0,
		TAG_BUFFER_INIT  = 2'd1,
		TAG_BUFFER_READY = 2'd2
	} tag_buffer_state_t;

endpackage

/* design/cmd_pkg.sv */
// command side types; kind encoding 2'd3 is unused and never issued by a compute unit
package cmd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// field widths
	////////////////////////////////////////////////////////////////////////////

	localparam int CU_WIDTH   = 2;
	localparam int ADDR_WIDTH = 32;
	localparam int CODE_WIDTH = 8;
	// read data beat width
	localparam int DATA_WIDTH = 32;

	// compute unit index, up to four units
	typedef logic [CU_WIDTH-1:0] cu_id_t;

	// what the command asks of shared memory
	typedef enum logic [1:0] {
		CMD_READ     = 2'd0,
		CMD_WRITE    = 2'd1,
		CMD_PREFETCH = 2'd2
	} cmd_kind_t;

	// owner record kept per tag in the tag RAM
	typedef struct packed {
		cu_id_t    cu;
		cmd_kind_t kind;
	} cmd_id_t;

	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// raw response code, passed through untouched
	typedef logic [CODE_WIDTH-1:0] rsp_code_t;

endpackage

/* design/tag_if.sv */
// issue to control link; take may only be raised while ready is high
`timescale 1ns/1ps

interface tag_if;

	// tag available and init walk done
	logic                ready;
	// a command consumes the head tag this cycle
	logic                take;
	// owner of the command being tagged
	cmd_pkg::cmd_id_t    id;
	// head of the tag FIFO
	tag_pkg::tag_t       tag;

	modport control (
		output ready,
		output tag,
		input  take,
		input  id
	);

	modport issue (
		input  ready,
		input  tag,
		output take,
		output id
	);

endinterface

/* design/lookup_if.sv */
// control to routing link; ids come back one cycle after their tag is presented
`timescale 1ns/1ps

interface lookup_if;

	// returning response, also frees its tag
	logic                rsp_valid;
	tag_pkg::tag_t       rsp_tag;
	cmd_pkg::cmd_id_t    rsp_id;

	// read data beat lookup, no side effect on the pool
	tag_pkg::tag_t       rd_tag;
	cmd_pkg::cmd_id_t    rd_id;

	modport control (
		input  rsp_valid,
		input  rsp_tag,
		output rsp_id,
		input  rd_tag,
		output rd_id
	);

	modport route (
		output rsp_valid,
		output rsp_tag,
		input  rsp_id,
		output rd_tag,
		input  rd_id
	);

endinterface

/* design/tag_fifo.sv */
// show-ahead tag FIFO of TAG_COUNT entries; push when full and pop when empty are dropped
`timescale 1ns/1ps

module tag_fifo (
	input  logic          clock,
	input  logic          rstn,
	input  logic          push,
	input  tag_pkg::tag_t data_in,
	input  logic          pop,
	output tag_pkg::tag_t data_out,
	output logic          full,
	output logic          alfull,
	output logic          empty,
	output logic          valid
);

	// storage, no reset on payload
	tag_pkg::tag_t                 mem [tag_pkg::TAG_COUNT];
	tag_pkg::tag_t                 wr_ptr;
	tag_pkg::tag_t                 rd_ptr;
	// one extra bit so a full pool is representable
	logic [tag_pkg::TAG_WIDTH:0]   count;
	logic                          do_push;
	logic                          do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	// pointers wrap on their own since the depth is 2**TAG_WIDTH
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leave count alone
			if (do_push & ~do_pop)
				count <= count + 1'b1;
			else if (do_pop & ~do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// head visible without a pop
	assign data_out = mem[rd_ptr];

	// flags
	assign empty  = (count == '0);
	assign full   = (count == tag_pkg::TAG_COUNT);
	// exactly one slot left
	assign alfull = (count == tag_pkg::TAG_COUNT - 1);
	// head slot holds a written tag
	assign valid  = (count != '0);

endmodule

/* design/tag_ram.sv */
// owner table per tag; reads are registered and a same-cycle write is not bypassed
`timescale 1ns/1ps

module tag_ram (
	input  logic             clock,
	input  logic             we,
	input  tag_pkg::tag_t    wr_addr,
	input  cmd_pkg::cmd_id_t data_in,
	input  tag_pkg::tag_t    rd_addr1,
	output cmd_pkg::cmd_id_t data_out1,
	input  tag_pkg::tag_t    rd_addr2,
	output cmd_pkg::cmd_id_t data_out2
);

	// one id line per tag
	cmd_pkg::cmd_id_t mem [tag_pkg::TAG_COUNT];

	always_ff @(posedge clock) begin
		if (we)
			mem[wr_addr] <= data_in;
	end

	// port 1 serves responses, port 2 read data
	always_ff @(posedge clock) begin
		data_out1 <= mem[rd_addr1];
		data_out2 <= mem[rd_addr2];
	end

endmodule

/* design/tag_control.sv */
// tag pool owner; disable restarts the walk but does not flush tags still outstanding
`timescale 1ns/1ps

module tag_control (
	input  logic     clock,
	input  logic     rstn,
	input  logic     enabled,
	tag_if.control   tags,
	lookup_if.control lookup
);

	logic                          rstn_meta;
	logic                          rstn_sync;
	logic                          enabled_q;
	tag_pkg::tag_buffer_state_t    state;
	tag_pkg::tag_buffer_state_t    state_next;
	// walk counter, wide enough to reach TAG_COUNT
	logic [tag_pkg::TAG_WIDTH:0]   walk_count;
	logic                          walk_push;
	logic                          walk_done;
	logic                          init_flag;
	logic                          fifo_push;
	logic                          fifo_pop;
	tag_pkg::tag_t                 fifo_in;
	tag_pkg::tag_t                 head_tag;
	logic                          fifo_full;
	logic                          fifo_alfull;
	logic                          fifo_empty;
	logic                          fifo_valid;

	////////////////////////////////////////////////////////////////////////////
	// reset sync and enable register
	////////////////////////////////////////////////////////////////////////////

	// async assert, sync release
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			rstn_meta <= 1'b0;
			rstn_sync <= 1'b0;
		end else begin
			rstn_meta <= 1'b1;
			rstn_sync <= rstn_meta;
		end
	end

	always_ff @(posedge clock or negedge rstn_sync) begin
		if (~rstn_sync)
			enabled_q <= 1'b0;
		else
			enabled_q <= enabled;
	end

	////////////////////////////////////////////////////////////////////////////
	// init walk FSM
	////////////////////////////////////////////////////////////////////////////

	// counter feeds tags 0..TAG_COUNT-1, one per cycle while room remains
	assign walk_done = (walk_count == tag_pkg::TAG_COUNT);
	assign walk_push = (state == tag_pkg::TAG_BUFFER_INIT) & ~fifo_full & ~walk_done;

	always_comb begin
		state_next = state;
		case (state)
			tag_pkg::TAG_BUFFER_RESET: state_next = tag_pkg::TAG_BUFFER_INIT;
			tag_pkg::TAG_BUFFER_INIT: begin
				// last push lands at the same edge as the state change
				if (fifo_full | (fifo_alfull & walk_push) | walk_done)
					state_next = tag_pkg::TAG_BUFFER_READY;
			end
			tag_pkg::TAG_BUFFER_READY: state_next = tag_pkg::TAG_BUFFER_READY;
			default: state_next = tag_pkg::TAG_BUFFER_RESET;
		endcase
	end

	// dropping enabled sends the FSM back to reset
	always_ff @(posedge clock or negedge rstn_sync) begin
		if (~rstn_sync) begin
			state      <= tag_pkg::TAG_BUFFER_RESET;
			walk_count <= '0;
		end else begin
			state <= enabled_q ? state_next : tag_pkg::TAG_BUFFER_RESET;
			if (state == tag_pkg::TAG_BUFFER_RESET)
				walk_count <= '0;
			else if (walk_push)
				walk_count <= walk_count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// push / pop mux
	////////////////////////////////////////////////////////////////////////////

	assign init_flag = (state != tag_pkg::TAG_BUFFER_READY);

	// counter owns the push side during init, returned tags afterwards
	assign fifo_push = init_flag ? walk_push : lookup.rsp_valid;
	assign fifo_in   = init_flag ? walk_count[tag_pkg::TAG_WIDTH-1:0] : lookup.rsp_tag;
	// no pops until the walk is over
	assign fifo_pop  = ~init_flag & tags.take;

	assign tags.ready = ~fifo_empty & fifo_valid & ~init_flag;
	assign tags.tag   = head_tag;

	tag_fifo u_tag_fifo (
		.clock    (clock),
		.rstn     (rstn_sync),
		.push     (fifo_push),
		.data_in  (fifo_in),
		.pop      (fifo_pop),
		.data_out (head_tag),
		.full     (fifo_full),
		.alfull   (fifo_alfull),
		.empty    (fifo_empty),
		.valid    (fifo_valid)
	);

	// issued tag is the head, so the owner lands at that address
	tag_ram u_tag_ram (
		.clock     (clock),
		.we        (fifo_pop),
		.wr_addr   (head_tag),
		.data_in   (tags.id),
		.rd_addr1  (lookup.rsp_tag),
		.data_out1 (lookup.rsp_id),
		.rd_addr2  (lookup.rd_tag),
		.data_out2 (lookup.rd_id)
	);

endmodule

/* design/cmd_issue.sv */
// tags one command per cycle; cmd_ready is combinational from the tag pool state
`timescale 1ns/1ps

module cmd_issue (
	input  logic               clock,
	input  logic               rstn,
	input  logic               cmd_valid,
	input  cmd_pkg::cu_id_t    cmd_cu,
	input  cmd_pkg::cmd_kind_t cmd_kind,
	input  cmd_pkg::addr_t     cmd_addr,
	output logic               cmd_ready,
	output logic               out_valid,
	output tag_pkg::tag_t      out_tag,
	output cmd_pkg::cmd_kind_t out_kind,
	output cmd_pkg::addr_t     out_addr,
	tag_if.issue               tags
);

	logic             take;
	cmd_pkg::cmd_id_t id_line;

	////////////////////////////////////////////////////////////////////////////
	// accept
	////////////////////////////////////////////////////////////////////////////

	// held cmd_valid just waits for a free tag
	assign cmd_ready = tags.ready;
	assign take      = cmd_valid & tags.ready;

	// owner record goes to the tag RAM
	always_comb begin
		id_line      = '0;
		id_line.cu   = cmd_cu;
		id_line.kind = cmd_kind;
	end

	assign tags.take = take;
	assign tags.id   = id_line;

	////////////////////////////////////////////////////////////////////////////
	// outgoing command register
	////////////////////////////////////////////////////////////////////////////

	// one cycle pulse per accepted command
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn)
			out_valid <= 1'b0;
		else
			out_valid <= take;
	end

	// payload, head tag sampled in the accept cycle
	always_ff @(posedge clock) begin
		if (take) begin
			out_tag  <= tags.tag;
			out_kind <= cmd_kind;
			out_addr <= cmd_addr;
		end
	end

endmodule

/* design/resp_route.sv */
// routes responses and read beats to their owners; outputs trail inputs by one cycle
`timescale 1ns/1ps

module resp_route (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            rsp_valid,
	input  tag_pkg::tag_t                   rsp_tag,
	input  cmd_pkg::rsp_code_t              rsp_code,
	input  logic                            rd_valid,
	input  tag_pkg::tag_t                   rd_tag,
	input  logic [cmd_pkg::DATA_WIDTH-1:0]  rd_data,
	output logic                            rsp_out_valid,
	output cmd_pkg::cu_id_t                 rsp_out_cu,
	output cmd_pkg::cmd_kind_t              rsp_out_kind,
	output cmd_pkg::rsp_code_t              rsp_out_code,
	output logic                            rd_out_valid,
	output cmd_pkg::cu_id_t                 rd_out_cu,
	output logic [cmd_pkg::DATA_WIDTH-1:0]  rd_out_data,
	lookup_if.route                         lookup
);

	logic                            rsp_valid_q;
	cmd_pkg::rsp_code_t              rsp_code_q;
	logic                            rd_valid_q;
	logic [cmd_pkg::DATA_WIDTH-1:0]  rd_data_q;

	// tags go straight to the RAM read ports
	assign lookup.rsp_valid = rsp_valid;
	assign lookup.rsp_tag   = rsp_tag;
	assign lookup.rd_tag    = rd_tag;

	////////////////////////////////////////////////////////////////////////////
	// delay to meet the registered RAM reads
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			rsp_valid_q <= 1'b0;
			rd_valid_q  <= 1'b0;
		end else begin
			rsp_valid_q <= rsp_valid;
			rd_valid_q  <= rd_valid;
		end
	end

	always_ff @(posedge clock) begin
		rsp_code_q <= rsp_code;
		rd_data_q  <= rd_data;
	end

	// split the id lines
	assign rsp_out_valid = rsp_valid_q;
	assign rsp_out_cu    = lookup.rsp_id.cu;
	assign rsp_out_kind  = lookup.rsp_id.kind;
	assign rsp_out_code  = rsp_code_q;

	// read beats only need the owning unit
	assign rd_out_valid  = rd_valid_q;
	assign rd_out_cu     = lookup.rd_id.cu;
	assign rd_out_data   = rd_data_q;

endmodule

/* design/tag_subsys_top.sv */
// tag subsystem top; one command at a time, no response flow control, no tag sanity checks
`timescale 1ns/1ps

module tag_subsys_top (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            enabled,
	// command in
	input  logic                            cmd_valid,
	input  cmd_pkg::cu_id_t                 cmd_cu,
	input  cmd_pkg::cmd_kind_t              cmd_kind,
	input  cmd_pkg::addr_t                  cmd_addr,
	output logic                            cmd_ready,
	// command out
	output logic                            out_valid,
	output tag_pkg::tag_t                   out_tag,
	output cmd_pkg::cmd_kind_t              out_kind,
	output cmd_pkg::addr_t                  out_addr,
	// response in and out
	input  logic                            rsp_valid,
	input  tag_pkg::tag_t                   rsp_tag,
	input  cmd_pkg::rsp_code_t              rsp_code,
	output logic                            rsp_out_valid,
	output cmd_pkg::cu_id_t                 rsp_out_cu,
	output cmd_pkg::cmd_kind_t              rsp_out_kind,
	output cmd_pkg::rsp_code_t              rsp_out_code,
	// read data in and out
	input  logic                            rd_valid,
	input  tag_pkg::tag_t                   rd_tag,
	input  logic [cmd_pkg::DATA_WIDTH-1:0]  rd_data,
	output logic                            rd_out_valid,
	output cmd_pkg::cu_id_t                 rd_out_cu,
	output logic [cmd_pkg::DATA_WIDTH-1:0]  rd_out_data
);

	tag_if    tags_bus ();
	lookup_if lookup_bus ();

	////////////////////////////////////////////////////////////////////////////
	// issue, control, route
	////////////////////////////////////////////////////////////////////////////

	cmd_issue u_cmd_issue (
		.clock     (clock),
		.rstn      (rstn),
		.cmd_valid (cmd_valid),
		.cmd_cu    (cmd_cu),
		.cmd_kind  (cmd_kind),
		.cmd_addr  (cmd_addr),
		.cmd_ready (cmd_ready),
		.out_valid (out_valid),
		.out_tag   (out_tag),
		.out_kind  (out_kind),
		.out_addr  (out_addr),
		.tags      (tags_bus.issue)
	);

	// reset is resynchronized in here
	tag_control u_tag_control (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (enabled),
		.tags    (tags_bus.control),
		.lookup  (lookup_bus.control)
	);

	resp_route u_resp_route (
		.clock         (clock),
		.rstn          (rstn),
		.rsp_valid     (rsp_valid),
		.rsp_tag       (rsp_tag),
		.rsp_code      (rsp_code),
		.rd_valid      (rd_valid),
		.rd_tag        (rd_tag),
		.rd_data       (rd_data),
		.rsp_out_valid (rsp_out_valid),
		.rsp_out_cu    (rsp_out_cu),
		.rsp_out_kind  (rsp_out_kind),
		.rsp_out_code  (rsp_out_code),
		.rd_out_valid  (rd_out_valid),
		.rd_out_cu     (rd_out_cu),
		.rd_out_data   (rd_out_data),
		.lookup        (lookup_bus.route)
	);

endmodule

/* dv/tb_tag_subsys.sv */
// tag subsystem testbench; responses and read beats only ever name outstanding tags
`timescale 1ns/1ps

module tb_tag_subsys;

	logic                            clock;
	logic                            rstn;
	logic                            enabled;
	logic                            cmd_valid;
	cmd_pkg::cu_id_t                 cmd_cu;
	cmd_pkg::cmd_kind_t              cmd_kind;
	cmd_pkg::addr_t                  cmd_addr;
	logic                            cmd_ready;
	logic                            out_valid;
	tag_pkg::tag_t                   out_tag;
	cmd_pkg::cmd_kind_t              out_kind;
	cmd_pkg::addr_t                  out_addr;
	logic                            rsp_valid;
	tag_pkg::tag_t                   rsp_tag;
	cmd_pkg::rsp_code_t              rsp_code;
	logic                            rsp_out_valid;
	cmd_pkg::cu_id_t                 rsp_out_cu;
	cmd_pkg::cmd_kind_t              rsp_out_kind;
	cmd_pkg::rsp_code_t              rsp_out_code;
	logic                            rd_valid;
	tag_pkg::tag_t                   rd_tag;
	logic [cmd_pkg::DATA_WIDTH-1:0]  rd_data;
	logic                            rd_out_valid;
	cmd_pkg::cu_id_t                 rd_out_cu;
	logic [cmd_pkg::DATA_WIDTH-1:0]  rd_out_data;

	// reference model of the free pool in FIFO order, tags in flight and owner per tag
	tag_pkg::tag_t                   free_q [$];
	tag_pkg::tag_t                   outstanding [$];
	cmd_pkg::cu_id_t                 tag_cu [tag_pkg::TAG_COUNT];
	cmd_pkg::cmd_kind_t              tag_kind [tag_pkg::TAG_COUNT];
	// set once the init walk is over
	bit                              ready_checked;

	tag_subsys_top uut (.*);

	// 40 ns period
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// failure reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected)
		else stop_on_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
			name, got, expected));
	endtask

	// each strobe reaches its output exactly one cycle later
	assert property (@(posedge clock) disable iff (!rstn)
		(cmd_valid && cmd_ready) |=> out_valid)
	else stop_on_failure("out_valid missing one cycle after an accepted command");
	assert property (@(posedge clock) disable iff (!rstn)
		out_valid |-> $past(cmd_valid && cmd_ready))
	else stop_on_failure("out_valid raised without an accepted command");
	assert property (@(posedge clock) disable iff (!rstn)
		rsp_valid |=> rsp_out_valid)
	else stop_on_failure("rsp_out_valid missing one cycle after a response");
	assert property (@(posedge clock) disable iff (!rstn)
		rd_valid |=> rd_out_valid)
	else stop_on_failure("rd_out_valid missing one cycle after a read beat");

	////////////////////////////////////////////////////////////////////////////
	// one clock of stimulus and checking
	////////////////////////////////////////////////////////////////////////////

	// called at a falling edge with inputs already driven
	task automatic run_cycle();
		logic                            accepted;
		tag_pkg::tag_t                   exp_tag;
		cmd_pkg::cmd_kind_t              exp_kind;
		cmd_pkg::addr_t                  exp_addr;
		logic                            exp_rsp;
		cmd_pkg::cu_id_t                 exp_rsp_cu;
		cmd_pkg::cmd_kind_t              exp_rsp_kind;
		cmd_pkg::rsp_code_t              exp_code;
		logic                            exp_rd;
		cmd_pkg::cu_id_t                 exp_rd_cu;
		logic [cmd_pkg::DATA_WIDTH-1:0]  exp_data;
		accepted = cmd_valid & cmd_ready;
		// ready tracks the free pool once the walk is done
		if (ready_checked)
			check_value("cmd_ready", cmd_ready, free_q.size() != 0);
		exp_rsp      = rsp_valid;
		exp_rsp_cu   = tag_cu[rsp_tag];
		exp_rsp_kind = tag_kind[rsp_tag];
		exp_code     = rsp_code;
		exp_rd       = rd_valid;
		exp_rd_cu    = tag_cu[rd_tag];
		exp_data     = rd_data;
		if (accepted) begin
			if (free_q.size() == 0)
				stop_on_failure("command accepted while no tag was free");
			// head of the pool is the tag issued
			exp_tag           = free_q.pop_front();
			exp_kind          = cmd_kind;
			exp_addr          = cmd_addr;
			tag_cu[exp_tag]   = cmd_cu;
			tag_kind[exp_tag] = cmd_kind;
			outstanding.push_back(exp_tag);
		end
		// returned tag joins the tail after any pop
		if (rsp_valid)
			free_q.push_back(rsp_tag);
		@(posedge clock);
		@(negedge clock);
		check_value("out_valid", out_valid, accepted);
		if (accepted) begin
			check_value("out_tag", out_tag, exp_tag);
			check_value("out_kind", out_kind, exp_kind);
			check_value("out_addr", out_addr, exp_addr);
		end
		check_value("rsp_out_valid", rsp_out_valid, exp_rsp);
		if (exp_rsp) begin
			check_value("rsp_out_cu", rsp_out_cu, exp_rsp_cu);
			check_value("rsp_out_kind", rsp_out_kind, exp_rsp_kind);
			check_value("rsp_out_code", rsp_out_code, exp_code);
		end
		check_value("rd_out_valid", rd_out_valid, exp_rd);
		if (exp_rd) begin
			check_value("rd_out_cu", rd_out_cu, exp_rd_cu);
			check_value("rd_out_data", rd_out_data, exp_data);
		end
	endtask

	// random payloads with tags picked among those in flight
	task automatic drive_cycle(input bit want_cmd, input bit want_rsp, input bit want_rd);
		int pick;
		cmd_valid = want_cmd;
		cmd_cu    = cmd_pkg::cu_id_t'($urandom);
		cmd_kind  = cmd_pkg::cmd_kind_t'($urandom % 3);
		cmd_addr  = $urandom;
		rsp_valid = 1'b0;
		rd_valid  = 1'b0;
		if (want_rd && outstanding.size() > 0) begin
			pick     = $urandom % outstanding.size();
			rd_valid = 1'b1;
			rd_tag   = outstanding[pick];
			rd_data  = $urandom;
		end
		if (want_rsp && outstanding.size() > 0) begin
			pick      = $urandom % outstanding.size();
			rsp_valid = 1'b1;
			rsp_tag   = outstanding[pick];
			rsp_code  = cmd_pkg::rsp_code_t'($urandom);
			outstanding.delete(pick);
		end
		run_cycle();
	endtask

	// walk takes one reset cycle plus one push per tag
	task automatic wait_for_ready();
		int                          cycles;
		tag_pkg::tag_buffer_state_t  ready_state;
		cycles      = 0;
		ready_state = tag_pkg::TAG_BUFFER_READY;
		while (!cmd_ready) begin
			if (cycles >= tag_pkg::TAG_COUNT + 4)
				stop_on_failure($sformatf("cmd_ready still low %0d cycles after enable, %s %s",
					cycles, "tag pool never reached", ready_state.name()));
			@(posedge clock);
			@(negedge clock);
			cycles++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h6f85_ac0d));
		rstn          = 1'b0;
		enabled       = 1'b0;
		cmd_valid     = 1'b0;
		cmd_cu        = '0;
		cmd_kind      = cmd_pkg::CMD_READ;
		cmd_addr      = '0;
		rsp_valid     = 1'b0;
		rsp_tag       = '0;
		rsp_code      = '0;
		rd_valid      = 1'b0;
		rd_tag        = '0;
		rd_data       = '0;
		ready_checked = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// idle while disabled
		repeat (4) begin
			run_cycle();
			check_value("cmd_ready", cmd_ready, 1'b0);
		end

		// init walk fills the pool in ascending order
		enabled = 1'b1;
		for (int i = 0; i < tag_pkg::TAG_COUNT; i++)
			free_q.push_back(tag_pkg::tag_t'(i));
		wait_for_ready();
		ready_checked = 1'b1;

		// draining the fresh pool yields tags in ascending order
		repeat (tag_pkg::TAG_COUNT)
			drive_cycle(1'b1, 1'b0, bit'($urandom % 2));

		// held command waits on the empty pool
		repeat (3)
			drive_cycle(1'b1, 1'b0, 1'b0);

		// everything at once
		drive_cycle(1'b1, 1'b1, 1'b1);
		drive_cycle(1'b1, 1'b1, 1'b1);
		repeat (80)
			drive_cycle(bit'($urandom % 2), bit'($urandom % 3 == 0), bit'($urandom % 2));

		// return every tag still in flight
		repeat (tag_pkg::TAG_COUNT + 1)
			drive_cycle(1'b0, 1'b1, 1'b1);
		drive_cycle(1'b0, 1'b0, 1'b0);

		// whole pool reissues in return order and then runs dry
		repeat (tag_pkg::TAG_COUNT)
			drive_cycle(1'b1, 1'b0, 1'b0);
		drive_cycle(1'b1, 1'b0, 1'b0);

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* vlog.f */
design/tag_pkg.sv
design/cmd_pkg.sv
design/tag_if.sv
design/lookup_if.sv
design/tag_fifo.sv
design/tag_ram.sv
design/tag_control.sv
design/cmd_issue.sv
design/resp_route.sv
design/tag_subsys_top.sv
dv/tb_tag_subsys.sv

/* Bender.yml */
package:
  name: tag_subsys

sources:
  - design/tag_pkg.sv
  - design/cmd_pkg.sv
  - design/tag_if.sv
  - design/lookup_if.sv
  - design/tag_fifo.sv
  - design/tag_ram.sv
  - design/tag_control.sv
  - design/cmd_issue.sv
  - design/resp_route.sv
  - design/tag_subsys_top.sv
  - target: test
    files:
      - dv/tb_tag_subsys.sv
